// File: list.f
+incdir+include
hw/div_pkg.sv
hw/exact_div_array.sv
hw/approx_div_array.sv
hw/div_error_monitor.sv
hw/div_compare_top.sv
verif/div_compare_tb.sv

// File: verif/div_vectors.txt
// dividend divisor exact_q exact_r approx_q approx_r, all hex
// overflow cases (high byte >= divisor) keep 00 in the four result columns
0064 0a 0a 00 00 64
0005 07 00 05 00 05
1234 56 36 10 1f fe
ffff ff 00 00 00 00
feff ff ff fe ff ff
0100 02 80 00 80 00
0000 00 00 00 00 00
0abc 0b f9 09 c3 ff
00c8 64 02 00 00 c8
8000 80 00 00 00 00
0040 01 40 00 40 00
3fff 40 ff 3f cf fe
7531 c8 96 01 9f fe
00ff ff 01 00 00 ff
0101 03 55 02 40 41
1234 00 00 00 00 00
2710 7f 4e 5e 47 ff
0080 81 00 80 00 80
4000 41 fc 04 cf ff
c350 90 00 00 00 00

// File: verif/div_compare_tb.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_compare_tb;

  localparam int NV       = 20;  // cases in the vector file
  localparam int CLEAR_AT = 10;  // stats_clear goes out before this case
  localparam int MAX_CYC  = 8 + 4*NV + 20;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  div_pkg::div_req_t     in_req;
  logic                  stats_clear;
  logic                  out_valid;
  div_pkg::div_cmp_t     out_cmp;
  logic [`DIV_CNT_W-1:0] sample_count;
  logic [`DIV_CNT_W-1:0] mismatch_count;
  logic [`DIV_D_W-1:0]   max_q_err;

  logic [15:0] vec_mem [0:6*NV-1];  // six words per case
  int          pend_idx [$];        // cases in flight
  int          pend_due [$];        // cycle in which out_valid is due
  int          drv_idx;
  int          cycle;
  int          errors;
  int          checked;
  integer      seed;
  int          exp_samples;
  int          exp_mism;
  int          exp_max;

  div_compare_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_req         (in_req),
    .stats_clear    (stats_clear),
    .out_valid      (out_valid),
    .out_cmp        (out_cmp),
    .sample_count   (sample_count),
    .mismatch_count (mismatch_count),
    .max_q_err      (max_q_err)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYC) begin
      $display("timeout after %0d cycles, %0d results outstanding and %0d errors so far",
               cycle, pend_idx.size(), errors);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare_stats(input string tag);
    if (sample_count !== exp_samples || mismatch_count !== exp_mism ||
        max_q_err !== exp_max) begin
      $display("error at %0t: %s statistics %0d/%0d/%0d, expected %0d/%0d/%0d",
               $time, tag, sample_count, mismatch_count, max_q_err,
               exp_samples, exp_mism, exp_max);
      errors++;
    end
  endtask

  task automatic verify_result();
    int          idx;
    int          due;
    logic [15:0] n;
    logic [7:0]  d, eq, er, aq, ar, qerr;
    logic        ovf, rmis, mis;
    idx = pend_idx.pop_front();
    due = pend_due.pop_front();
    n   = vec_mem[6*idx];
    d   = vec_mem[6*idx+1][7:0];
    eq  = vec_mem[6*idx+2][7:0];
    er  = vec_mem[6*idx+3][7:0];
    aq  = vec_mem[6*idx+4][7:0];
    ar  = vec_mem[6*idx+5][7:0];
    ovf = (n[15:8] >= d);  // covers d == 0 too
    checked++;
    if (due != cycle) begin
      $display("error at %0t: case %0d out_valid in cycle %0d, expected cycle %0d",
               $time, idx, cycle, due);
      errors++;
    end
    if (out_cmp.overflow !== ovf) begin
      $display("error at %0t: case %0d overflow %b, expected %b", $time, idx,
               out_cmp.overflow, ovf);
      errors++;
    end
    if (!ovf) begin
      qerr = (eq >= aq) ? eq - aq : aq - eq;
      rmis = (er != ar);
      mis  = (eq != aq) || rmis;
      if ({out_cmp.exact, out_cmp.approx} !== {eq, er, aq, ar}) begin
        $display("error at %0t: case %0d q/r exact %h/%h approx %h/%h, expected %h/%h %h/%h",
                 $time, idx, out_cmp.exact.q, out_cmp.exact.r, out_cmp.approx.q,
                 out_cmp.approx.r, eq, er, aq, ar);
        errors++;
      end
      if ({out_cmp.q_err, out_cmp.r_mismatch, out_cmp.mismatch} !== {qerr, rmis, mis}) begin
        $display("error at %0t: case %0d q_err/r_mismatch/mismatch %h/%b/%b, expected %h/%b/%b",
                 $time, idx, out_cmp.q_err, out_cmp.r_mismatch, out_cmp.mismatch,
                 qerr, rmis, mis);
        errors++;
      end
      exp_samples++;
      if (mis)
        exp_mism++;
      if (qerr > exp_max)
        exp_max = qerr;
    end
    compare_stats("running");  // stats move on the out_valid edge
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_valid) begin
        pend_idx.push_back(drv_idx);
        pend_due.push_back(cycle + 2);
      end
      if (pend_due.size() > 0 && pend_due[0] < cycle) begin
        $display("out_valid never came for case %0d, it was due in cycle %0d",
                 pend_idx[0], pend_due[0]);
        errors++;
        void'(pend_idx.pop_front());
        void'(pend_due.pop_front());
      end
      if (out_valid && pend_idx.size() == 0) begin
        $display("out_valid went high in cycle %0d with no request pending", cycle);
        errors++;
      end else if (out_valid) begin
        verify_result();
      end
    end
  end

  task automatic clear_stats();
    @(posedge clk);
    in_valid <= 1'b0;
    while (pend_idx.size() > 0) begin
      @(negedge clk);
    end
    compare_stats("before clear");
    @(posedge clk);
    stats_clear <= 1'b1;
    @(posedge clk);
    stats_clear <= 1'b0;
    exp_samples = 0;
    exp_mism    = 0;
    exp_max     = 0;
    @(negedge clk);
    compare_stats("after clear");
  endtask

  initial begin
    int idle;
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_req      = '0;
    stats_clear = 1'b0;
    drv_idx     = 0;
    cycle       = 0;
    errors      = 0;
    checked     = 0;
    seed        = 75;
    exp_samples = 0;
    exp_mism    = 0;
    exp_max     = 0;
    $readmemh("verif/div_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[6*NV-1])) begin
      $display("the vector file verif/div_vectors.txt could not be read in full");
      errors++;
    end
    repeat (8) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("error at %0t: out_valid is %b during reset", $time, out_valid);
        errors++;
      end
      compare_stats("reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NV; i++) begin
      if (i == CLEAR_AT) begin
        clear_stats();
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_req   <= {vec_mem[6*i], vec_mem[6*i+1][7:0]};
      drv_idx  <= i;
      idle = (i < 3) ? 0 : {$random(seed)} % 3;  // first cases back to back
      repeat (idle) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    while (pend_idx.size() > 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    compare_stats("final");
    $display("%0d errors, %0d results checked", errors, checked);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hw/div_compare_top.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_compare_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  div_pkg::div_req_t     in_req,
  input  logic                  stats_clear,
  output logic                  out_valid,
  output div_pkg::div_cmp_t     out_cmp,
  output logic [`DIV_CNT_W-1:0] sample_count,
  output logic [`DIV_CNT_W-1:0] mismatch_count,
  output logic [`DIV_D_W-1:0]   max_q_err
);

  div_pkg::div_req_t req_q;
  logic              req_valid_q;
  div_pkg::div_res_t exact_res;
  div_pkg::div_res_t approx_res;

  // input stage, one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
      req_q       <= '0;
    end else begin
      req_valid_q <= in_valid;
      if (in_valid) begin
        req_q <= in_req;
      end
    end
  end

  // both arrays see the same registered request
  exact_div_array u_exact (
    .req (req_q),
    .res (exact_res)
  );

  approx_div_array u_approx (
    .req (req_q),
    .res (approx_res)
  );

  div_error_monitor u_monitor (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req_q),
    .req_valid      (req_valid_q),
    .exact_res      (exact_res),
    .approx_res     (approx_res),
    .stats_clear    (stats_clear),
    .out_valid      (out_valid),
    .out_cmp        (out_cmp),
    .sample_count   (sample_count),
    .mismatch_count (mismatch_count),
    .max_q_err      (max_q_err)
  );

endmodule

// File: hw/div_error_monitor.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_error_monitor (
  input  logic                  clk,
  input  logic                  rst_n,
  input  div_pkg::div_req_t     req,
  input  logic                  req_valid,
  input  div_pkg::div_res_t     exact_res,
  input  div_pkg::div_res_t     approx_res,
  input  logic                  stats_clear,
  output logic                  out_valid,
  output div_pkg::div_cmp_t     out_cmp,
  output logic [`DIV_CNT_W-1:0] sample_count,
  output logic [`DIV_CNT_W-1:0] mismatch_count,
  output logic [`DIV_D_W-1:0]   max_q_err
);

  div_pkg::div_cmp_t   cmp_d;
  logic                sample_ok;
  logic [`DIV_N_W-1:0] recon;  // exact q * d + r

  always_comb begin
    cmp_d.exact  = exact_res;
    cmp_d.approx = approx_res;
    if (exact_res.q >= approx_res.q) begin
      cmp_d.q_err = exact_res.q - approx_res.q;
    end else begin
      cmp_d.q_err = approx_res.q - exact_res.q;
    end
    cmp_d.r_mismatch = (exact_res.r != approx_res.r);
    cmp_d.overflow   = (req.n[`DIV_N_W-1 -: `DIV_D_W] >= req.d);
    cmp_d.mismatch   = (exact_res.q != approx_res.q) | cmp_d.r_mismatch;
  end

  assign sample_ok = req_valid & ~cmp_d.overflow;  // overflows stay out of the stats

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      out_cmp <= cmp_d;
    end
  end

  // stats move on the same edge as out_valid, clear has priority
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_count   <= '0;
      mismatch_count <= '0;
      max_q_err      <= '0;
    end else if (stats_clear) begin
      sample_count   <= '0;
      mismatch_count <= '0;
      max_q_err      <= '0;
    end else if (sample_ok) begin
      if (sample_count != '1) begin
        sample_count <= sample_count + 1'b1;
      end
      if (cmp_d.mismatch && mismatch_count != '1) begin
        mismatch_count <= mismatch_count + 1'b1;
      end
      if (cmp_d.q_err > max_q_err) begin
        max_q_err <= cmp_d.q_err;
      end
    end
  end

  assign recon = {{(`DIV_N_W-`DIV_D_W){1'b0}}, exact_res.q} * {{(`DIV_N_W-`DIV_D_W){1'b0}}, req.d}
               + {{(`DIV_N_W-`DIV_D_W){1'b0}}, exact_res.r};

  // exact array output checked against the request that drove it
  a_exact_ok: assert property (@(posedge clk) disable iff (!rst_n)
    sample_ok |-> (recon == req.n) && (exact_res.r < req.d));

  a_mismatch_mono: assert property (@(posedge clk) disable iff (!rst_n)
    !stats_clear |=> mismatch_count >= $past(mismatch_count));

  a_valid_src: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(req_valid));

endmodule

// File: hw/approx_div_array.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module approx_div_array (
  input  div_pkg::div_req_t req,
  output div_pkg::div_res_t res
);

  localparam int W           = `DIV_D_W;
  localparam int APPROX_ROWS = 6;  // quotient bits 0..5 use the cheap cell

  logic [W-1:0] row_in  [W];
  logic [W-1:0] row_top;
  logic [W-1:0] row_out [W];
  logic [W-1:0] q;

  // exact borrow subtractor, {borrow out, difference}
  function automatic logic [1:0] sub_cell(
    input logic x,
    input logic y,
    input logic bin
  );
    sub_cell = {(~x & y) | (~(x ^ y) & bin), x ^ y ^ bin};
  endfunction

  // simplified cell: borrow out stuck at 1, difference ignores the minuend bit
  function automatic logic [1:0] approx_cell(
    input logic y,
    input logic bin
  );
    approx_cell = {1'b1, y | bin};
  endfunction

  for (genvar i = 0; i < W; i++) begin : g_row
    logic [W:0]   borrow;
    logic [W-1:0] diff;

    if (i == W-1) begin : g_first
      assign row_in[i]  = req.n[`DIV_N_W-2 -: W];
      assign row_top[i] = req.n[`DIV_N_W-1];
    end else begin : g_next
      assign row_in[i]  = {row_out[i+1][W-2:0], req.n[i]};
      assign row_top[i] = row_out[i+1][W-1];
    end

    if (i < APPROX_ROWS) begin : g_approx
      // the final borrow is always 1, so q[i] reduces to row_top[i]
      always_comb begin
        borrow[0] = 1'b0;
        for (int j = 0; j < W; j++) begin
          {borrow[j+1], diff[j]} = approx_cell(req.d[j], borrow[j]);
        end
      end
    end else begin : g_exact
      always_comb begin
        borrow[0] = 1'b0;
        for (int j = 0; j < W; j++) begin
          {borrow[j+1], diff[j]} = sub_cell(row_in[i][j], req.d[j], borrow[j]);
        end
      end
    end

    assign q[i]       = row_top[i] | ~borrow[W];
    assign row_out[i] = q[i] ? diff : row_in[i];
  end

  assign res.q = q;
  assign res.r = row_out[0];

endmodule

// File: hw/exact_div_array.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module exact_div_array (
  input  div_pkg::div_req_t req,
  output div_pkg::div_res_t res
);

  localparam int W = `DIV_D_W;

  logic [W-1:0] row_in  [W];  // partial remainder entering each row
  logic [W-1:0] row_top;      // bit above row_in, forces the subtract when set
  logic [W-1:0] row_out [W];  // remainder leaving each row
  logic [W-1:0] q;

  // full borrow subtractor, returns {borrow out, difference}
  function automatic logic [1:0] sub_cell(
    input logic x,
    input logic y,
    input logic bin
  );
    sub_cell = {(~x & y) | (~(x ^ y) & bin), x ^ y ^ bin};
  endfunction

  // row i produces quotient bit i, the msb row comes first
  for (genvar i = 0; i < W; i++) begin : g_row
    logic [W:0]   borrow;
    logic [W-1:0] diff;

    if (i == W-1) begin : g_first
      assign row_in[i]  = req.n[`DIV_N_W-2 -: W];
      assign row_top[i] = req.n[`DIV_N_W-1];
    end else begin : g_next
      // shift in the next dividend bit below the previous remainder
      assign row_in[i]  = {row_out[i+1][W-2:0], req.n[i]};
      assign row_top[i] = row_out[i+1][W-1];
    end

    always_comb begin
      borrow[0] = 1'b0;
      for (int j = 0; j < W; j++) begin
        {borrow[j+1], diff[j]} = sub_cell(row_in[i][j], req.d[j], borrow[j]);
      end
    end

    // no final borrow means the divisor fits
    assign q[i]       = row_top[i] | ~borrow[W];
    assign row_out[i] = q[i] ? diff : row_in[i];  // restore on a zero bit
  end

  assign res.q = q;
  assign res.r = row_out[0];

endmodule

// File: hw/div_pkg.sv
`include "div_defines.svh"

package div_pkg;

  // one division request
  typedef struct packed {
    logic [`DIV_N_W-1:0] n;
    logic [`DIV_D_W-1:0] d;
  } div_req_t;

  // one divider result
  typedef struct packed {
    logic [`DIV_D_W-1:0] q;
    logic [`DIV_D_W-1:0] r;
  } div_res_t;

  // one compared sample as seen at the monitor output
  typedef struct packed {
    div_res_t            exact;
    div_res_t            approx;
    logic [`DIV_D_W-1:0] q_err;       // |exact.q - approx.q|
    logic                r_mismatch;
    logic                overflow;    // high byte >= divisor, incl. divide by zero
    logic                mismatch;    // quotient or remainder differs
  } div_cmp_t;

endpackage

// File: include/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// dividend width
`define DIV_N_W 16

// divisor, quotient and remainder width
`define DIV_D_W 8

// statistics counters
`define DIV_CNT_W 16

`endif
